// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := icache_tb
FILELIST  := icache.f
OBJDIR    := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: design/icache_array.sv
// Cache storage array with one synchronous read port and one write port
`timescale 1ns/1ps

module icache_array
  import icache_pkg::*;
#(
  parameter type entry_t = tag_entry_t
)
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      rd_v_i,
  input  logic [ICACHE_INDEX_W-1:0] rd_index_i,
  input  logic                      wr_v_i,
  input  logic [ICACHE_INDEX_W-1:0] wr_index_i,
  input  entry_t                    wr_data_i,
  output entry_t                    rd_data_o
);

  entry_t mem_r [ICACHE_SETS];

  // Cleared entries read as invalid tags
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < ICACHE_SETS; i++)
      begin
        mem_r[i] <= '0;
      end
      rd_data_o <= '0;
    end
    else
    begin
      if (wr_v_i)
        mem_r[wr_index_i] <= wr_data_i;
      // Old contents on a same-index write
      if (rd_v_i)
        rd_data_o <= mem_r[rd_index_i];
    end
  end

endmodule

// File: design/icache_hit_select.sv
// Way merge, word selection and registered hit or miss result
`timescale 1ns/1ps

module icache_hit_select
  import icache_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,

  // Lookup stage
  input  logic                          stage_v_i,
  input  fetch_addr_t                   stage_addr_i,
  input  way_result_t [ICACHE_WAYS-1:0] results_i,

  // Fetch result
  output word_t                         data_o,
  output logic                          data_v_o,
  output logic                          miss_v_o,

  // Towards miss control
  output logic                          miss_detect_o,
  output line_addr_t                    miss_line_o
);

  logic [ICACHE_WAYS-1:0]       hit_vec;
  logic                         hit_any;
  block_t                       hit_block;
  logic [ICACHE_WORD_IDX_W-1:0] word_idx;
  word_t                        word_sel;

  // One-hot hits, so an OR of masked blocks is the mux
  always_comb
  begin
    hit_block = '0;
    for (int w = 0; w < ICACHE_WAYS; w++)
    begin
      hit_vec[w] = results_i[w].hit;
      if (results_i[w].hit)
        hit_block = hit_block | results_i[w].block;
    end
  end

  assign hit_any  = |hit_vec;
  assign word_idx = stage_addr_i.offset[ICACHE_BYTE_OFF_W +: ICACHE_WORD_IDX_W];
  assign word_sel = hit_block[word_idx];

  // Miss report for the state machine, same cycle as the lookup
  assign miss_detect_o = stage_v_i & ~hit_any;
  assign miss_line_o   = '{tag: stage_addr_i.tag, index: stage_addr_i.index};

  //////////////////////////////////////////////////////////////////////////
  // Verify stage outputs
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      data_v_o <= 1'b0;
      miss_v_o <= 1'b0;
    end
    else
    begin
      data_v_o <= stage_v_i & hit_any;
      miss_v_o <= miss_detect_o;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (stage_v_i)
      data_o <= word_sel;
  end

endmodule

// File: design/icache_lookup.sv
// Fetch acceptance, tag lookup stage and index steering to the cache ways
`timescale 1ns/1ps

module icache_lookup
  import icache_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,

  // Fetch port
  input  logic                      fetch_v_i,
  input  fetch_addr_t               fetch_addr_i,
  input  logic                      fetch_ready_i,

  // Read and fill towards the ways
  output logic                      rd_v_o,
  output logic [ICACHE_INDEX_W-1:0] rd_index_o,
  output fill_t                     fill_o,
  input  fill_t                     fill_i,

  // Lookup stage towards hit select
  output logic                      stage_v_o,
  output fetch_addr_t               stage_addr_o,
  input  logic                      squash_i
);

  logic        accept;
  logic        stage_v_r;
  fetch_addr_t stage_addr_r;
  logic        fill_v_r;
  fill_t       fill_r;

  assign accept = fetch_v_i & fetch_ready_i;

  // Array read issues on the accepting edge
  assign rd_v_o     = accept;
  assign rd_index_o = fetch_addr_i.index;

  //////////////////////////////////////////////////////////////////////////
  // Stage 1 register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      stage_v_r <= 1'b0;
    else
      stage_v_r <= accept & ~squash_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      stage_addr_r <= fetch_addr_i;
  end

  assign stage_v_o    = stage_v_r;
  assign stage_addr_o = stage_addr_r;

  //////////////////////////////////////////////////////////////////////////
  // Fill alignment
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      fill_v_r <= 1'b0;
    else
      fill_v_r <= fill_i.wr_v;
  end

  // Payload only moves when a fill is present
  always_ff @(posedge clk_i)
  begin
    if (fill_i.wr_v)
      fill_r <= fill_i;
  end

  always_comb
  begin
    fill_o      = fill_r;
    fill_o.wr_v = fill_v_r;
  end

endmodule

// File: design/icache_miss_ctrl.sv
// Blocking miss FSM with four-phase refill request and round-robin victim
`timescale 1ns/1ps

module icache_miss_ctrl
  import icache_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  // From hit select
  input  logic       miss_detect_i,
  input  line_addr_t miss_line_i,

  // Fetch flow control
  output logic       fetch_ready_o,
  output logic       squash_o,

  // Refill port
  output logic       mem_req_o,
  output line_addr_t mem_addr_o,
  input  logic       mem_ack_i,
  input  block_t     mem_block_i,

  // Block write towards the ways
  output fill_t      fill_o
);

  typedef enum logic [1:0] {
    e_ready,
    e_wait_ack,
    e_wait_release
  } state_e;

  state_e                     state_r;
  state_e                     state_n;
  logic                       mem_req_r;
  line_addr_t                 miss_line_r;
  logic [ICACHE_WAY_ID_W-1:0] victim_r;
  logic                       fill_v;
  logic                       start_miss;

  assign start_miss = (state_r == e_ready) & miss_detect_i;
  assign fill_v     = (state_r == e_wait_ack) & mem_req_r & mem_ack_i;

  //////////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_ready:        if (miss_detect_i) state_n = e_wait_ack;
      e_wait_ack:     if (fill_v) state_n = e_wait_release;
      // Wait for the responder to drop its ack
      e_wait_release: if (!mem_ack_i) state_n = e_ready;
      default:        state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r   <= e_ready;
      mem_req_r <= 1'b0;
      victim_r  <= '0;
    end
    else
    begin
      state_r   <= state_n;
      // Request one cycle into wait-ack, drop after the ack
      mem_req_r <= (state_r == e_wait_ack) & ~fill_v;
      if (fill_v)
        victim_r <= (victim_r == ICACHE_WAY_ID_W'(ICACHE_WAYS - 1)) ? '0 : victim_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start_miss)
      miss_line_r <= miss_line_i;
  end

  // The fetch accepted with the missing one is dropped
  assign squash_o      = start_miss;
  assign fetch_ready_o = (state_r == e_ready);
  assign mem_req_o     = mem_req_r;
  assign mem_addr_o    = miss_line_r;

  assign fill_o.wr_v  = fill_v;
  assign fill_o.index = miss_line_r.index;
  assign fill_o.way   = ICACHE_WAYS'(1) << victim_r;
  assign fill_o.tag   = miss_line_r.tag;
  assign fill_o.block = mem_block_i;

endmodule

// File: design/icache_pkg.sv
// Instruction cache package with geometry constants and shared packed types
package icache_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////////////////////////////

  localparam int ICACHE_WAYS     = 4;
  localparam int ICACHE_SETS     = 16;
  localparam int ICACHE_WORD_W   = 32;
  localparam int ICACHE_WORDS    = 4;

  // Byte address fields
  localparam int ICACHE_TAG_W    = 8;
  localparam int ICACHE_INDEX_W  = 4;
  localparam int ICACHE_OFFSET_W = 4;

  // Derived widths
  localparam int ICACHE_WAY_ID_W   = $clog2(ICACHE_WAYS);
  localparam int ICACHE_WORD_IDX_W = $clog2(ICACHE_WORDS);
  localparam int ICACHE_BYTE_OFF_W = ICACHE_OFFSET_W - ICACHE_WORD_IDX_W;

  //////////////////////////////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////////////////////////////

  typedef logic [ICACHE_WORD_W-1:0] word_t;

  // Word 0 sits in the low bits of the block
  typedef word_t [ICACHE_WORDS-1:0] block_t;

  typedef struct packed {
    logic [ICACHE_TAG_W-1:0]    tag;
    logic [ICACHE_INDEX_W-1:0]  index;
    logic [ICACHE_OFFSET_W-1:0] offset;
  } fetch_addr_t;

  // Block address as sent on the refill port
  typedef struct packed {
    logic [ICACHE_TAG_W-1:0]   tag;
    logic [ICACHE_INDEX_W-1:0] index;
  } line_addr_t;

  typedef struct packed {
    logic                    valid;
    logic [ICACHE_TAG_W-1:0] tag;
  } tag_entry_t;

  // Whole-block write into one way
  typedef struct packed {
    logic                      wr_v;
    logic [ICACHE_INDEX_W-1:0] index;
    logic [ICACHE_WAYS-1:0]    way;
    logic [ICACHE_TAG_W-1:0]   tag;
    block_t                    block;
  } fill_t;

  // Per-way report in the verify cycle
  typedef struct packed {
    logic   hit;
    block_t block;
  } way_result_t;

endpackage

// File: design/icache_top.sv
// Instruction cache top level with lookup, ways, hit select and miss control
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,

  // Fetch port
  input  logic        fetch_v_i,
  input  fetch_addr_t fetch_addr_i,
  output logic        fetch_ready_o,
  output word_t       data_o,
  output logic        data_v_o,
  output logic        miss_v_o,

  // Refill port
  output logic        mem_req_o,
  output line_addr_t  mem_addr_o,
  input  logic        mem_ack_i,
  input  block_t      mem_block_i
);

  logic                          rd_v;
  logic [ICACHE_INDEX_W-1:0]     rd_index;
  fill_t                         way_fill;
  fill_t                         miss_fill;
  logic                          stage_v;
  fetch_addr_t                   stage_addr;
  logic                          squash;
  way_result_t [ICACHE_WAYS-1:0] way_results;
  logic                          miss_detect;
  line_addr_t                    miss_line;

  icache_lookup i_lookup (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_v_i     (fetch_v_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_i (fetch_ready_o),
    .rd_v_o        (rd_v),
    .rd_index_o    (rd_index),
    .fill_o        (way_fill),
    .fill_i        (miss_fill),
    .stage_v_o     (stage_v),
    .stage_addr_o  (stage_addr),
    .squash_i      (squash)
  );

  for (genvar w = 0; w < ICACHE_WAYS; w++)
  begin : g_way
    icache_way #(.WAY_ID(w)) i_way (
      .clk_i (clk_i), .reset_i (reset_i),
      .rd_v_i (rd_v), .rd_index_i (rd_index), .fill_i (way_fill),
      .lookup_tag_i (stage_addr.tag), .result_o (way_results[w])
    );
  end

  icache_hit_select i_hit_select (
    .clk_i (clk_i), .reset_i (reset_i),
    .stage_v_i (stage_v), .stage_addr_i (stage_addr), .results_i (way_results),
    .data_o (data_o), .data_v_o (data_v_o), .miss_v_o (miss_v_o),
    .miss_detect_o (miss_detect), .miss_line_o (miss_line)
  );

  icache_miss_ctrl i_miss_ctrl (
    .clk_i (clk_i), .reset_i (reset_i),
    .miss_detect_i (miss_detect), .miss_line_i (miss_line),
    .fetch_ready_o (fetch_ready_o), .squash_o (squash),
    .mem_req_o (mem_req_o), .mem_addr_o (mem_addr_o),
    .mem_ack_i (mem_ack_i), .mem_block_i (mem_block_i), .fill_o (miss_fill)
  );

endmodule

// File: design/icache_way.sv
// One cache way holding tags and blocks, with its own tag compare
`timescale 1ns/1ps

module icache_way
  import icache_pkg::*;
#(
  parameter int WAY_ID = 0
)
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      rd_v_i,
  input  logic [ICACHE_INDEX_W-1:0] rd_index_i,
  input  fill_t                     fill_i,
  input  logic [ICACHE_TAG_W-1:0]   lookup_tag_i,
  output way_result_t               result_o
);

  logic       wr_v;
  tag_entry_t wr_tag;
  tag_entry_t rd_tag;
  block_t     rd_block;

  // Only the way picked by the one-hot victim takes the fill
  assign wr_v   = fill_i.wr_v & fill_i.way[WAY_ID];
  assign wr_tag = '{valid: 1'b1, tag: fill_i.tag};

  icache_array #(
    .entry_t (tag_entry_t)
  ) i_tag_array (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rd_v_i     (rd_v_i),
    .rd_index_i (rd_index_i),
    .wr_v_i     (wr_v),
    .wr_index_i (fill_i.index),
    .wr_data_i  (wr_tag),
    .rd_data_o  (rd_tag)
  );

  icache_array #(
    .entry_t (block_t)
  ) i_block_array (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rd_v_i     (rd_v_i),
    .rd_index_i (rd_index_i),
    .wr_v_i     (wr_v),
    .wr_index_i (fill_i.index),
    .wr_data_i  (fill_i.block),
    .rd_data_o  (rd_block)
  );

  // Verify cycle compare
  assign result_o.hit   = rd_tag.valid & (rd_tag.tag == lookup_tag_i);
  assign result_o.block = rd_block;

endmodule

// File: icache.f
design/icache_pkg.sv
design/icache_array.sv
design/icache_lookup.sv
design/icache_way.sv
design/icache_hit_select.sv
design/icache_miss_ctrl.sv
design/icache_top.sv
sim/icache_properties.sv
sim/icache_tb.sv

// File: sim/icache_properties.sv
// Bound checker for fetch results, refill handshake and fetch flow control
`timescale 1ns/1ps

module icache_properties
  import icache_pkg::*;
(
  input logic        clk_i,
  input logic        reset_i,
  input logic        fetch_v_i,
  input fetch_addr_t fetch_addr_i,
  input logic        fetch_ready_o,
  input word_t       data_o,
  input logic        data_v_o,
  input logic        miss_v_o,
  input logic        mem_req_o,
  input line_addr_t  mem_addr_o,
  input logic        mem_ack_i
);

  int unsigned                fail_count = 0;
  logic                       accept;
  fetch_addr_t                addr_d1;
  fetch_addr_t                addr_d2;
  line_addr_t                 missed_line;
  tag_entry_t                 model_tags [ICACHE_SETS][ICACHE_WAYS];
  logic [ICACHE_WAY_ID_W-1:0] model_victim;

  assign accept = fetch_v_i & fetch_ready_o;

  // Word k of a line is the constant ORed with the line address and k
  function automatic word_t expected_word(input fetch_addr_t a);
    return 32'hc0de_0000 | {18'h0, a.tag, a.index, a.offset[3:2]};
  endfunction

  function automatic logic resident(input fetch_addr_t a);
    logic found;
    found = 1'b0;
    for (int w = 0; w < ICACHE_WAYS; w++)
    begin
      if (model_tags[a.index][w].valid && (model_tags[a.index][w].tag == a.tag))
        found = 1'b1;
    end
    return found;
  endfunction

  task automatic note_failure(input string msg);
    fail_count++;
    $error("%s", msg);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference contents and fetch address pipeline
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    addr_d1 <= fetch_addr_i;
    addr_d2 <= addr_d1;
  end

  // Line of the fetch that last missed
  always_ff @(posedge clk_i)
  begin
    if (miss_v_o)
      missed_line <= '{tag: addr_d2.tag, index: addr_d2.index};
  end

  // One fill per refill with the victim at the fill count modulo the way count
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < ICACHE_SETS; s++)
      begin
        for (int w = 0; w < ICACHE_WAYS; w++)
          model_tags[s][w] <= '0;
      end
      model_victim <= '0;
    end
    else if (mem_req_o && mem_ack_i)
    begin
      model_tags[missed_line.index][model_victim] <= '{valid: 1'b1, tag: missed_line.tag};
      model_victim <= model_victim + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fetch results
  ////////////////////////////////////////////////////////////////////////////

  a_result_once: assert property (@(posedge clk_i) disable iff (reset_i)
    $past(accept, 2) && !$past(miss_v_o) |-> data_v_o ^ miss_v_o)
    else note_failure("Accepted fetch gave no single result two cycles later");

  // Fetch right behind a miss is dropped
  a_squash: assert property (@(posedge clk_i) disable iff (reset_i)
    $past(accept, 2) && $past(miss_v_o) |-> !data_v_o && !miss_v_o)
    else note_failure("Fetch following a miss was not squashed");

  a_no_spurious: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o || miss_v_o |-> $past(accept, 2))
    else note_failure("Result appeared without an accepted fetch");

  a_hit_model: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o || miss_v_o |-> data_v_o == resident(addr_d2))
    else note_failure($sformatf("ERR %0t: hit or miss differs from the fill history", $time));

  a_data_pattern: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o |-> data_o == expected_word(addr_d2))
    else note_failure($sformatf("ERR %0t: data_o differs from the refill pattern", $time));

  ////////////////////////////////////////////////////////////////////////////
  // Refill handshake and flow control
  ////////////////////////////////////////////////////////////////////////////

  a_refill_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o |-> mem_addr_o == missed_line)
    else note_failure($sformatf("ERR %0t: mem_addr_o differs from the missing line", $time));

  a_addr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o && $past(mem_req_o) |-> $stable(mem_addr_o))
    else note_failure("Refill address changed while the request was high");

  a_req_release: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(mem_req_o) |-> $past(mem_ack_i))
    else note_failure("Refill request dropped before the ack arrived");

  a_req_rise: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(mem_req_o) |-> !$past(mem_ack_i))
    else note_failure("New refill request raised while the ack was still high");

  a_ready_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_v_o || mem_req_o |-> !fetch_ready_o)
    else note_failure("Fetch port was ready during a miss");

  a_ready_return: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(fetch_ready_o) |-> !$past(mem_ack_i) && $past(mem_ack_i, 2))
    else note_failure("Fetch port became ready at the wrong point after the ack fell");

  a_reset_state: assert property (@(posedge clk_i)
    $past(reset_i) |-> !data_v_o && !miss_v_o && !mem_req_o && fetch_ready_o)
    else note_failure("Outputs were not in their reset state");

endmodule

bind icache_top icache_properties i_icache_properties (.*);

// File: sim/icache_tb.sv
// Instruction cache testbench with refill responder, fetch stimulus and watchdog
`timescale 1ns/1ps

module icache_tb
  import icache_pkg::*;
();

  logic        clk_i;
  logic        reset_i;
  logic        fetch_v_i;
  fetch_addr_t fetch_addr_i;
  logic        fetch_ready_o;
  word_t       data_o;
  logic        data_v_o;
  logic        miss_v_o;
  logic        mem_req_o;
  line_addr_t  mem_addr_o;
  logic        mem_ack_i;
  block_t      mem_block_i;
  logic [31:0] lfsr_r = 32'heaa2;
  int unsigned test_count = 0;

  icache_top i_icache_top (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      fb     = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
      lfsr_r = {lfsr_r[30:0], fb};
      value  = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic block_t pattern_block(input line_addr_t line_addr);
    block_t blk;
    for (int k = 0; k < ICACHE_WORDS; k++)
      blk[k] = 32'hc0de_0000 | {18'h0, line_addr, k[1:0]};
    return blk;
  endfunction

  function automatic fetch_addr_t make_addr(input logic [7:0] tag, input logic [3:0] index,
                                            input logic [1:0] word);
    fetch_addr_t a;
    a.tag    = tag;
    a.index  = index;
    a.offset = {word, 2'b00};
    return a;
  endfunction

  function automatic int unsigned failures();
    return i_icache_top.i_icache_properties.fail_count;
  endfunction

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  // Leaves fetch_v_i high so callers can stream fetches
  task automatic accept_fetch(input fetch_addr_t addr);
    fetch_v_i    = 1'b1;
    fetch_addr_i = addr;
    while (!fetch_ready_o)
      idle_cycles(1);
    idle_cycles(1);
  endtask

  // Reissue after a miss until the line hits
  task automatic fetch_until_hit(input fetch_addr_t addr);
    logic done;
    done = 1'b0;
    while (!done)
    begin
      accept_fetch(addr);
      fetch_v_i = 1'b0;
      idle_cycles(1);
      done = data_v_o;
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    $display("test %s done at %0t, assertion failures so far %0d", name, $time, failures());
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, refill responder and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Four-phase responder with a random 1 to 7 cycle answer delay and a slow release
  initial
  begin : refill_responder
    int unsigned delay;
    int unsigned hold;
    mem_ack_i   = 1'b0;
    mem_block_i = '0;
    forever
    begin
      idle_cycles(1);
      if (mem_req_o && !mem_ack_i)
      begin
        delay = 1 + (take_bits(3) % 7);
        idle_cycles(delay);
        mem_block_i = pattern_block(mem_addr_o);
        mem_ack_i   = 1'b1;
        do
          idle_cycles(1);
        while (mem_req_o);
        // Ack may stay high for up to 7 more cycles
        hold = take_bits(3);
        repeat (hold)
          idle_cycles(1);
        mem_ack_i = 1'b0;
      end
    end
  end

  initial
  begin : watchdog
    int unsigned limit;
    // Budget for reset, twenty slow refills with slow release, the fetch stream and a margin
    limit = 16 + 20 * 32 + 40 + 100;
    repeat (limit) @(posedge clk_i);
    $display("Watchdog timeout at %0t, the tests did not finish", $time);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    fetch_addr_t stream_q [$];
    logic [7:0]  tag;
    reset_i      = 1'b1;
    fetch_v_i    = 1'b0;
    fetch_addr_i = '0;
    idle_cycles(16);
    reset_i = 1'b0;
    idle_cycles(2);
    report_test("reset");

    fetch_until_hit(make_addr(8'h12, 4'h3, 2'd1));
    report_test("cold_miss");

    // Fill two more lines and then fetch on every cycle
    fetch_until_hit(make_addr(8'h21, 4'h1, 2'd0));
    fetch_until_hit(make_addr(8'h33, 4'h2, 2'd0));
    for (int w = 0; w < ICACHE_WORDS; w++)
    begin
      stream_q.push_back(make_addr(8'h12, 4'h3, w[1:0]));
      stream_q.push_back(make_addr(8'h21, 4'h1, w[1:0]));
      stream_q.push_back(make_addr(8'h33, 4'h2, w[1:0]));
    end
    foreach (stream_q[i])
      accept_fetch(stream_q[i]);
    fetch_v_i = 1'b0;
    idle_cycles(3);
    report_test("back_to_back");

    // Five tags in set 9 so the fifth fill evicts the first
    for (int t = 0; t < 5; t++)
      fetch_until_hit(make_addr(8'h40 + 8'(t), 4'h9, 2'd2));
    for (int t = 1; t < 5; t++)
      fetch_until_hit(make_addr(8'h40 + 8'(t), 4'h9, 2'd3));
    fetch_until_hit(make_addr(8'h40, 4'h9, 2'd0));
    report_test("replacement");

    for (int s = 0; s < 6; s++)
    begin
      tag = 8'(take_bits(8));
      fetch_until_hit(make_addr(tag, 4'(s + 10), 2'(s)));
    end
    report_test("refill_handshake");

    // Second fetch is accepted in the cycle the first one misses
    accept_fetch(make_addr(8'h77, 4'h5, 2'd0));
    accept_fetch(make_addr(8'h21, 4'h1, 2'd1));
    fetch_v_i = 1'b0;
    fetch_until_hit(make_addr(8'h21, 4'h1, 2'd1));
    fetch_until_hit(make_addr(8'h77, 4'h5, 2'd0));
    report_test("squash");

    idle_cycles(4);
    $display("tests %0d, assertion failures %0d", test_count, failures());
    if (failures() == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
